//--- rtl/soc_mem_pkg.sv
// memory subsystem common types
`default_nettype none

package soc_mem_pkg;

    localparam int ADDR_W     = 32;           // byte address
    localparam int DATA_W     = 64;           // one beat
    localparam int STRB_W     = DATA_W / 8;   // one strobe bit per byte
    localparam int LINE_BEATS = 4;            // cache line = 4 beats, 32 bytes

    // on-chip memory window
    localparam logic [ADDR_W-1:0] MEM_BASE = 32'h8000_0000;
    localparam int MEM_WORDS = 256;           // 2 KiB of 64-bit words

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] word_t;
    typedef logic [STRB_W-1:0] strb_t;
    typedef logic [LINE_BEATS*DATA_W-1:0] line_t;   // beat 0 in low word

    // request kinds from the core
    typedef enum logic [1:0] {
        RD_WORD = 2'd0,   // single word read
        RD_LINE = 2'd1,   // four beat refill
        WR_WORD = 2'd2    // masked single word write
    } req_kind_e;

    // request queue entry
    typedef struct packed {
        req_kind_e kind;
        addr_t     addr;
        word_t     wdata;
        strb_t     wmask;
    } mem_req_t;

    // response queue entry, single read data sits in word 0
    typedef struct packed {
        req_kind_e kind;
        logic      err;    // any non-okay resp in the transaction
        line_t     line;
    } mem_rsp_t;

endpackage

`default_nettype wire

//--- rtl/axi_pkg.sv
// axi4 encodings
`default_nettype none

package axi_pkg;

    typedef logic [1:0] resp_t;

    // burst type, only incr is issued
    localparam logic [1:0] BURST_INCR = 2'b01;

    // 8 byte beats
    localparam logic [2:0] SIZE_8B = 3'b011;

    // refill burst, len is beats minus one
    localparam logic [7:0] LINE_LEN = 8'(soc_mem_pkg::LINE_BEATS - 1);

    // response codes
    localparam resp_t RESP_OKAY   = 2'b00;
    localparam resp_t RESP_SLVERR = 2'b10;   // slave saw a bad access
    localparam resp_t RESP_DECERR = 2'b11;   // nothing at that address

endpackage

`default_nettype wire

//--- rtl/sync_fifo.sv
// two entry synchronous queue
`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
    parameter type item_t = logic
) (
    input  wire        clk,
    input  wire        arst_n_i,
    // write side
    input  wire        valid_i,
    output logic       ready_o,
    input  wire item_t data_i,
    // read side
    output logic       valid_o,
    input  wire        ready_i,
    output item_t      data_o
);

    item_t      mem_q [2];   // storage, no reset
    logic       wr_ptr_q;    // next slot to fill
    logic       rd_ptr_q;    // oldest entry
    logic [1:0] count_q;     // 0..2
    logic       push;
    logic       pop;

    assign ready_o = (count_q != 2'd2);   // full when both used
    assign valid_o = (count_q != 2'd0);
    assign data_o  = mem_q[rd_ptr_q];     // head shows the cycle after push

    assign push = valid_i & ready_o;
    assign pop  = valid_o & ready_i;

    // pointers and fill level
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr_q <= 1'b0;
            rd_ptr_q <= 1'b0;
            count_q  <= 2'd0;
        end else begin
            if (push) wr_ptr_q <= ~wr_ptr_q;   // wraps at 2
            if (pop)  rd_ptr_q <= ~rd_ptr_q;
            count_q <= count_q + 2'(push) - 2'(pop);   // both at once keeps level
        end
    end

    always_ff @(posedge clk) begin
        if (push) mem_q[wr_ptr_q] <= data_i;
    end

endmodule

`default_nettype wire

//--- rtl/axi_rw_master.sv
// axi4 read/write master
`timescale 1ns/1ps
`default_nettype none

module axi_rw_master (
    input  wire                      clk,
    input  wire                      arst_n_i,
    // request queue side
    input  wire                      req_valid_i,
    output logic                     req_ready_o,
    input  wire soc_mem_pkg::mem_req_t req_i,
    // response queue side
    output logic                     rsp_valid_o,
    input  wire                      rsp_ready_i,
    output soc_mem_pkg::mem_rsp_t    rsp_o,
    // aw / w / b
    output logic                     aw_valid_o,
    input  wire                      aw_ready_i,
    output soc_mem_pkg::addr_t       aw_addr_o,
    output logic                     w_valid_o,
    input  wire                      w_ready_i,
    output soc_mem_pkg::word_t       w_data_o,
    output soc_mem_pkg::strb_t       w_strb_o,
    output logic                     w_last_o,
    input  wire                      b_valid_i,
    output logic                     b_ready_o,
    input  wire axi_pkg::resp_t      b_resp_i,
    // ar / r
    output logic                     ar_valid_o,
    input  wire                      ar_ready_i,
    output soc_mem_pkg::addr_t       ar_addr_o,
    output logic [7:0]               ar_len_o,
    output logic [2:0]               ar_size_o,
    output logic [1:0]               ar_burst_o,
    input  wire                      r_valid_i,
    output logic                     r_ready_o,
    input  wire soc_mem_pkg::word_t  r_data_i,
    input  wire axi_pkg::resp_t      r_resp_i,
    input  wire                      r_last_i
);

    typedef enum logic [2:0] {
        ST_IDLE, ST_RD_ADDR, ST_RD_DATA, ST_WR, ST_WR_RESP, ST_PUSH
    } state_e;

    state_e                 state_q;
    soc_mem_pkg::req_kind_e kind_q;
    soc_mem_pkg::addr_t     addr_q;    // already line aligned for refills
    soc_mem_pkg::word_t     wdata_q;
    soc_mem_pkg::strb_t     wmask_q;
    soc_mem_pkg::line_t     line_q;    // beats gathered here
    logic                   err_q;
    logic [1:0]             beat_q;    // beat position in the line
    logic                   aw_pend_q; // aw not yet taken
    logic                   w_pend_q;  // w not yet taken
    logic                   req_fire;
    logic                   r_fire;

    // idle and room in the response queue, back-pressure path
    assign req_ready_o = (state_q == ST_IDLE) & rsp_ready_i;
    assign req_fire    = req_valid_i & req_ready_o;
    assign r_fire      = r_valid_i & r_ready_o;

    assign ar_valid_o = (state_q == ST_RD_ADDR);
    assign ar_addr_o  = addr_q;
    assign ar_len_o   = (kind_q == soc_mem_pkg::RD_LINE) ? axi_pkg::LINE_LEN : 8'd0;
    assign ar_size_o  = axi_pkg::SIZE_8B;
    assign ar_burst_o = axi_pkg::BURST_INCR;
    assign r_ready_o  = (state_q == ST_RD_DATA);

    assign aw_valid_o = aw_pend_q;
    assign aw_addr_o  = addr_q;
    assign w_valid_o  = w_pend_q;
    assign w_data_o   = wdata_q;
    assign w_strb_o   = wmask_q;
    assign w_last_o   = 1'b1;   // single beat writes
    assign b_ready_o  = (state_q == ST_WR_RESP);

    assign rsp_valid_o = (state_q == ST_PUSH);
    assign rsp_o       = '{kind: kind_q, err: err_q, line: line_q};

    // control
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q   <= ST_IDLE;
            err_q     <= 1'b0;
            beat_q    <= 2'd0;
            aw_pend_q <= 1'b0;
            w_pend_q  <= 1'b0;
        end else begin
            unique case (state_q)
                ST_IDLE: begin
                    if (req_fire) begin
                        err_q  <= 1'b0;
                        beat_q <= 2'd0;
                        if (req_i.kind == soc_mem_pkg::WR_WORD) begin
                            state_q   <= ST_WR;   // aw and w together
                            aw_pend_q <= 1'b1;
                            w_pend_q  <= 1'b1;
                        end else begin
                            state_q <= ST_RD_ADDR;
                        end
                    end
                end
                ST_RD_ADDR: if (ar_ready_i) state_q <= ST_RD_DATA;
                ST_RD_DATA: begin
                    if (r_fire) begin
                        err_q  <= err_q | (r_resp_i != axi_pkg::RESP_OKAY);
                        beat_q <= beat_q + 2'd1;
                        if (r_last_i) state_q <= ST_PUSH;
                    end
                end
                ST_WR: begin
                    if (aw_ready_i) aw_pend_q <= 1'b0;   // each drops on its own
                    if (w_ready_i) w_pend_q <= 1'b0;
                    if ((!aw_pend_q || aw_ready_i) && (!w_pend_q || w_ready_i)) begin
                        state_q <= ST_WR_RESP;
                    end
                end
                ST_WR_RESP: begin
                    if (b_valid_i) begin
                        err_q   <= err_q | (b_resp_i != axi_pkg::RESP_OKAY);
                        state_q <= ST_PUSH;
                    end
                end
                ST_PUSH: if (rsp_ready_i) state_q <= ST_IDLE;   // room reserved at accept
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // payload, captured at accept and filled by r beats
    always_ff @(posedge clk) begin
        if (req_fire) begin
            kind_q  <= req_i.kind;
            wdata_q <= req_i.wdata;
            wmask_q <= req_i.wmask;
            line_q  <= '0;   // unused words read back as zero
            if (req_i.kind == soc_mem_pkg::RD_LINE) begin
                // align down to the 32 byte line
                addr_q <= req_i.addr
                        & ~soc_mem_pkg::addr_t'(soc_mem_pkg::LINE_BEATS * soc_mem_pkg::STRB_W - 1);
            end else begin
                addr_q <= req_i.addr;
            end
        end else if (r_fire) begin
            line_q[beat_q*soc_mem_pkg::DATA_W +: soc_mem_pkg::DATA_W] <= r_data_i;
        end
    end

endmodule

`default_nettype wire

//--- rtl/axi_mem_slave.sv
// axi4 on-chip memory slave
`timescale 1ns/1ps
`default_nettype none

module axi_mem_slave (
    input  wire                     clk,
    input  wire                     arst_n_i,
    // aw / w / b
    input  wire                     aw_valid_i,
    output logic                    aw_ready_o,
    input  wire soc_mem_pkg::addr_t aw_addr_i,
    input  wire                     w_valid_i,
    output logic                    w_ready_o,
    input  wire soc_mem_pkg::word_t w_data_i,
    input  wire soc_mem_pkg::strb_t w_strb_i,
    input  wire                     w_last_i,
    output logic                    b_valid_o,
    input  wire                     b_ready_i,
    output axi_pkg::resp_t          b_resp_o,
    // ar / r
    input  wire                     ar_valid_i,
    output logic                    ar_ready_o,
    input  wire soc_mem_pkg::addr_t ar_addr_i,
    input  wire [7:0]               ar_len_i,
    input  wire [2:0]               ar_size_i,
    input  wire [1:0]               ar_burst_i,
    output logic                    r_valid_o,
    input  wire                     r_ready_i,
    output soc_mem_pkg::word_t      r_data_o,
    output axi_pkg::resp_t          r_resp_o,
    output logic                    r_last_o
);

    typedef enum logic [1:0] {S_IDLE, S_READ, S_BRESP} state_e;

    soc_mem_pkg::word_t mem_q [soc_mem_pkg::MEM_WORDS];   // contents not reset
    state_e             state_q;
    soc_mem_pkg::addr_t rd_addr_q;   // current beat address
    logic [7:0]         len_q;
    logic [7:0]         cnt_q;       // beats already sent
    logic [2:0]         size_q;
    logic [1:0]         burst_q;
    axi_pkg::resp_t     b_resp_q;
    axi_pkg::resp_t     wr_resp;
    logic               wr_fire;

    // inside MEM_BASE .. MEM_BASE + 2 KiB
    function automatic logic in_win(input soc_mem_pkg::addr_t a);
        return (a >= soc_mem_pkg::MEM_BASE) && (a < soc_mem_pkg::MEM_BASE
               + soc_mem_pkg::addr_t'(soc_mem_pkg::MEM_WORDS * soc_mem_pkg::STRB_W));
    endfunction

    // word index, base is 2 KiB aligned
    function automatic logic [$clog2(soc_mem_pkg::MEM_WORDS)-1:0] word_idx(
        input soc_mem_pkg::addr_t a
    );
        return a[$clog2(soc_mem_pkg::STRB_W) +: $clog2(soc_mem_pkg::MEM_WORDS)];
    endfunction

    assign ar_ready_o = (state_q == S_IDLE);   // reads win a tie
    // write taken once aw and w are both there
    assign wr_fire    = (state_q == S_IDLE) & ~ar_valid_i & aw_valid_i & w_valid_i;
    assign aw_ready_o = wr_fire;
    assign w_ready_o  = wr_fire;

    always_comb begin
        if (!in_win(aw_addr_i)) begin
            wr_resp = axi_pkg::RESP_DECERR;   // dropped
        end else if (!w_last_i || (w_strb_i == '0)) begin
            wr_resp = axi_pkg::RESP_SLVERR;   // nothing written
        end else begin
            wr_resp = axi_pkg::RESP_OKAY;
        end
    end

    assign r_valid_o = (state_q == S_READ);
    assign r_last_o  = (cnt_q == len_q);
    assign r_resp_o  = in_win(rd_addr_q) ? axi_pkg::RESP_OKAY : axi_pkg::RESP_DECERR;
    assign r_data_o  = in_win(rd_addr_q) ? mem_q[word_idx(rd_addr_q)] : '0;   // holds w/o ready
    assign b_valid_o = (state_q == S_BRESP);
    assign b_resp_o  = b_resp_q;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= S_IDLE;
            cnt_q   <= 8'd0;
        end else begin
            unique case (state_q)
                S_IDLE: begin
                    if (ar_valid_i) begin
                        state_q <= S_READ;   // first beat next cycle
                        cnt_q   <= 8'd0;
                    end else if (wr_fire) begin
                        state_q <= S_BRESP;
                    end
                end
                S_READ: begin
                    if (r_ready_i) begin
                        cnt_q <= cnt_q + 8'd1;
                        if (r_last_o) state_q <= S_IDLE;
                    end
                end
                S_BRESP: if (b_ready_i) state_q <= S_IDLE;
                default: state_q <= S_IDLE;
            endcase
        end
    end

    // burst address and write path
    always_ff @(posedge clk) begin
        if (ar_valid_i && ar_ready_o) begin
            rd_addr_q <= ar_addr_i;
            len_q     <= ar_len_i;
            size_q    <= ar_size_i;
            burst_q   <= ar_burst_i;
        end else if (r_valid_o && r_ready_i && burst_q == axi_pkg::BURST_INCR) begin
            rd_addr_q <= rd_addr_q + (soc_mem_pkg::addr_t'(1) << size_q);   // next word
        end
        if (wr_fire) begin
            b_resp_q <= wr_resp;
        end
        if (wr_fire && wr_resp == axi_pkg::RESP_OKAY) begin
            for (int b = 0; b < soc_mem_pkg::STRB_W; b++) begin
                if (w_strb_i[b]) mem_q[word_idx(aw_addr_i)][b*8 +: 8] <= w_data_i[b*8 +: 8];
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/mem_subsys_top.sv
// memory subsystem top level
`timescale 1ns/1ps
`default_nettype none

module mem_subsys_top (
    input  wire                         clk,
    input  wire                         arst_n_i,
    // core requests
    input  wire                         req_valid_i,
    output logic                        req_ready_o,
    input  wire soc_mem_pkg::req_kind_e req_kind_i,
    input  wire soc_mem_pkg::addr_t     req_addr_i,
    input  wire soc_mem_pkg::word_t     req_wdata_i,
    input  wire soc_mem_pkg::strb_t     req_wmask_i,
    // core responses, in request order
    output logic                        rsp_valid_o,
    input  wire                         rsp_ready_i,
    output soc_mem_pkg::req_kind_e      rsp_kind_o,
    output logic                        rsp_err_o,
    output soc_mem_pkg::line_t          rsp_line_o
);

    soc_mem_pkg::mem_req_t req_in;    // packed core request
    soc_mem_pkg::mem_req_t req_head;  // queue head to master
    soc_mem_pkg::mem_rsp_t rsp_new;   // master result
    soc_mem_pkg::mem_rsp_t rsp_out;
    logic                  req_valid, req_ready;
    logic                  rsp_push, rsp_room;

    // axi4 between master and memory
    logic                  aw_valid, aw_ready;
    soc_mem_pkg::addr_t    aw_addr;
    logic                  w_valid, w_ready, w_last;
    soc_mem_pkg::word_t    w_data;
    soc_mem_pkg::strb_t    w_strb;
    logic                  b_valid, b_ready;
    axi_pkg::resp_t        b_resp;
    logic                  ar_valid, ar_ready;
    soc_mem_pkg::addr_t    ar_addr;
    logic [7:0]            ar_len;
    logic [2:0]            ar_size;
    logic [1:0]            ar_burst;
    logic                  r_valid, r_ready, r_last;
    soc_mem_pkg::word_t    r_data;
    axi_pkg::resp_t        r_resp;

    assign req_in = '{kind: req_kind_i, addr: req_addr_i, wdata: req_wdata_i,
                      wmask: req_wmask_i};
    assign rsp_kind_o = rsp_out.kind;
    assign rsp_err_o  = rsp_out.err;
    assign rsp_line_o = rsp_out.line;

    sync_fifo #(.item_t(soc_mem_pkg::mem_req_t)) u_req_q (
        .clk(clk), .arst_n_i(arst_n_i),
        .valid_i(req_valid_i), .ready_o(req_ready_o), .data_i(req_in),
        .valid_o(req_valid), .ready_i(req_ready), .data_o(req_head)
    );

    axi_rw_master u_axi_rw (
        .clk(clk), .arst_n_i(arst_n_i),
        .req_valid_i(req_valid), .req_ready_o(req_ready), .req_i(req_head),
        .rsp_valid_o(rsp_push), .rsp_ready_i(rsp_room), .rsp_o(rsp_new),
        .aw_valid_o(aw_valid), .aw_ready_i(aw_ready), .aw_addr_o(aw_addr),
        .w_valid_o(w_valid), .w_ready_i(w_ready), .w_data_o(w_data),
        .w_strb_o(w_strb), .w_last_o(w_last),
        .b_valid_i(b_valid), .b_ready_o(b_ready), .b_resp_i(b_resp),
        .ar_valid_o(ar_valid), .ar_ready_i(ar_ready), .ar_addr_o(ar_addr),
        .ar_len_o(ar_len), .ar_size_o(ar_size), .ar_burst_o(ar_burst),
        .r_valid_i(r_valid), .r_ready_o(r_ready), .r_data_i(r_data),
        .r_resp_i(r_resp), .r_last_i(r_last)
    );

    // response queue, its ready throttles new requests
    sync_fifo #(.item_t(soc_mem_pkg::mem_rsp_t)) u_rsp_q (
        .clk(clk), .arst_n_i(arst_n_i),
        .valid_i(rsp_push), .ready_o(rsp_room), .data_i(rsp_new),
        .valid_o(rsp_valid_o), .ready_i(rsp_ready_i), .data_o(rsp_out)
    );

    axi_mem_slave u_axi_mem (
        .clk(clk), .arst_n_i(arst_n_i),
        .aw_valid_i(aw_valid), .aw_ready_o(aw_ready), .aw_addr_i(aw_addr),
        .w_valid_i(w_valid), .w_ready_o(w_ready), .w_data_i(w_data),
        .w_strb_i(w_strb), .w_last_i(w_last),
        .b_valid_o(b_valid), .b_ready_i(b_ready), .b_resp_o(b_resp),
        .ar_valid_i(ar_valid), .ar_ready_o(ar_ready), .ar_addr_i(ar_addr),
        .ar_len_i(ar_len), .ar_size_i(ar_size), .ar_burst_i(ar_burst),
        .r_valid_o(r_valid), .r_ready_i(r_ready), .r_data_o(r_data),
        .r_resp_o(r_resp), .r_last_o(r_last)
    );

endmodule

`default_nettype wire

//--- sim/tb_mem_subsys.sv
// memory subsystem testbench
`timescale 1ns/1ps
`default_nettype none

module tb_mem_subsys;

    localparam int N_INIT         = soc_mem_pkg::MEM_WORDS;   // one write per word
    localparam int N_MIXED        = 600;
    localparam int TIMEOUT_CYCLES = (N_INIT + N_MIXED) * 16;
    localparam int WIN_BYTES      = soc_mem_pkg::MEM_WORDS * soc_mem_pkg::STRB_W;

    logic                   clk;
    logic                   arst_n_i;
    logic                   req_valid_i;
    logic                   req_ready_o;
    soc_mem_pkg::req_kind_e req_kind_i;
    soc_mem_pkg::addr_t     req_addr_i;
    soc_mem_pkg::word_t     req_wdata_i;
    soc_mem_pkg::strb_t     req_wmask_i;
    logic                   rsp_valid_o;
    logic                   rsp_ready_i;
    soc_mem_pkg::req_kind_e rsp_kind_o;
    logic                   rsp_err_o;
    soc_mem_pkg::line_t     rsp_line_o;

    int seed;
    int rsp_seed;   // ready stream of its own
    int cycles;
    int line_errs;
    int err_errs;
    int kind_errs;
    int other_errs;

    // reference memory
    soc_mem_pkg::word_t model_mem [soc_mem_pkg::MEM_WORDS];
    bit                 written [soc_mem_pkg::MEM_WORDS];   // all bytes known

    // expected responses in issue order
    string                  exp_name_q [$];
    soc_mem_pkg::req_kind_e exp_kind_q [$];
    logic                   exp_err_q [$];
    soc_mem_pkg::line_t     exp_line_q [$];
    bit                     exp_chk_q [$];   // 0 when line is not compared

    // main process scratch
    soc_mem_pkg::req_kind_e kind;
    soc_mem_pkg::addr_t     addr;
    soc_mem_pkg::word_t     wdata;
    soc_mem_pkg::strb_t     wmask;
    int                     idx;
    int                     sel;
    bit                     outside;
    string                  name;

    mem_subsys_top uut (
        .clk(clk), .arst_n_i(arst_n_i),
        .req_valid_i(req_valid_i), .req_ready_o(req_ready_o), .req_kind_i(req_kind_i),
        .req_addr_i(req_addr_i), .req_wdata_i(req_wdata_i), .req_wmask_i(req_wmask_i),
        .rsp_valid_o(rsp_valid_o), .rsp_ready_i(rsp_ready_i), .rsp_kind_o(rsp_kind_o),
        .rsp_err_o(rsp_err_o), .rsp_line_o(rsp_line_o)
    );

    always #2 clk = ~clk;   // 4 ns period

    function automatic bit in_window(input soc_mem_pkg::addr_t a);
        soc_mem_pkg::addr_t off;
        off = a - soc_mem_pkg::MEM_BASE;   // wraps below base
        return off < WIN_BYTES;
    endfunction

    task automatic check_line(input string tname, input soc_mem_pkg::line_t exp,
                              input soc_mem_pkg::line_t act);
        if (act !== exp) begin
            line_errs++;
            $display("Error %s: line expected %h, actual %h", tname, exp, act);
        end
    endtask

    task automatic check_err(input string tname, input logic exp, input logic act);
        if (act !== exp) begin
            err_errs++;
            $display("Error %s: err expected %b, actual %b", tname, exp, act);
        end
    endtask

    task automatic check_kind(input string tname, input soc_mem_pkg::req_kind_e exp,
                              input soc_mem_pkg::req_kind_e act);
        if (act !== exp) begin
            kind_errs++;
            $display("Error %s: kind expected %0d, actual %0d", tname, exp, act);
        end
    endtask

    // expected response from the model and model update for writes
    task automatic model_req(input string tname, input soc_mem_pkg::req_kind_e k,
                             input soc_mem_pkg::addr_t a, input soc_mem_pkg::word_t d,
                             input soc_mem_pkg::strb_t m);
        soc_mem_pkg::line_t line;
        logic               err;
        bit                 chk;
        int                 w;
        int                 base;
        line = '0;
        chk  = 1'b1;
        err  = !in_window(a);   // decode error gives a zero line
        w    = int'((a - soc_mem_pkg::MEM_BASE) >> 3);
        if (!err) begin
            case (k)
                soc_mem_pkg::RD_WORD: begin
                    line[soc_mem_pkg::DATA_W-1:0] = model_mem[w];
                    chk = written[w];
                end
                soc_mem_pkg::RD_LINE: begin
                    base = w & ~(soc_mem_pkg::LINE_BEATS - 1);   // line aligned
                    for (int b = 0; b < soc_mem_pkg::LINE_BEATS; b++) begin
                        line[b*soc_mem_pkg::DATA_W +: soc_mem_pkg::DATA_W] = model_mem[base+b];
                        chk &= written[base+b];
                    end
                end
                default: begin
                    if (m == '0) begin
                        err = 1'b1;   // slave error leaves the word untouched
                    end else begin
                        for (int b = 0; b < soc_mem_pkg::STRB_W; b++) begin
                            if (m[b]) model_mem[w][b*8 +: 8] = d[b*8 +: 8];
                        end
                        if (m == '1) written[w] = 1'b1;
                    end
                end
            endcase
        end
        if (k == soc_mem_pkg::WR_WORD) chk = 1'b0;   // no data back
        exp_name_q.push_back(tname);
        exp_kind_q.push_back(k);
        exp_err_q.push_back(err);
        exp_line_q.push_back(line);
        exp_chk_q.push_back(chk);
    endtask

    // hold the request until the queue takes it
    task automatic send_req(input soc_mem_pkg::req_kind_e k, input soc_mem_pkg::addr_t a,
                            input soc_mem_pkg::word_t d, input soc_mem_pkg::strb_t m);
        logic taken;
        req_valid_i = 1'b1;
        req_kind_i  = k;
        req_addr_i  = a;
        req_wdata_i = d;
        req_wmask_i = m;
        taken = 1'b0;
        while (!taken) begin
            @(negedge clk);
            taken = req_ready_o;   // transfer on the coming edge
            @(posedge clk);
        end
        #1;
        req_valid_i = 1'b0;
    endtask

    task automatic issue(input string tname, input soc_mem_pkg::req_kind_e k,
                         input soc_mem_pkg::addr_t a, input soc_mem_pkg::word_t d,
                         input soc_mem_pkg::strb_t m);
        model_req(tname, k, a, d, m);
        send_req(k, a, d, m);
    endtask

    task automatic take_rsp();
        string              tname;
        soc_mem_pkg::line_t exp_line;
        bit                 chk;
        if (exp_kind_q.size() == 0) begin
            other_errs++;
            $display("a response came back with no request waiting for it");
        end else begin
            tname    = exp_name_q.pop_front();
            exp_line = exp_line_q.pop_front();
            chk      = exp_chk_q.pop_front();
            check_kind(tname, exp_kind_q.pop_front(), rsp_kind_o);
            check_err(tname, exp_err_q.pop_front(), rsp_err_o);
            if (chk) check_line(tname, exp_line, rsp_line_o);
        end
    endtask

    // response side drops ready about a quarter of the time
    initial begin
        @(posedge arst_n_i);
        forever begin
            @(posedge clk);
            #1;
            rsp_ready_i = ($unsigned($random(rsp_seed)) % 4) != 0;
            @(negedge clk);
            if (rsp_valid_o && rsp_ready_i) take_rsp();   // pops on next edge
        end
    end

    // watchdog
    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        clk         = 1'b0;
        arst_n_i    = 1'b0;
        req_valid_i = 1'b0;
        req_kind_i  = soc_mem_pkg::RD_WORD;
        req_addr_i  = '0;
        req_wdata_i = '0;
        req_wmask_i = '0;
        rsp_ready_i = 1'b0;
        seed        = 29279;
        rsp_seed    = 29279 + 1;
        line_errs   = 0;
        err_errs    = 0;
        kind_errs   = 0;
        other_errs  = 0;
        for (int i = 0; i < soc_mem_pkg::MEM_WORDS; i++) written[i] = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        arst_n_i = 1'b1;

        // fill every word with a full mask
        for (int i = 0; i < N_INIT; i++) begin
            wdata = {$random(seed), $random(seed)};
            issue("init_wr", soc_mem_pkg::WR_WORD,
                  soc_mem_pkg::MEM_BASE + soc_mem_pkg::addr_t'(i * 8), wdata, '1);
        end

        // mixed traffic
        for (int n = 0; n < N_MIXED; n++) begin
            sel     = $unsigned($random(seed)) % 8;
            idx     = $unsigned($random(seed)) % soc_mem_pkg::MEM_WORDS;
            outside = ($unsigned($random(seed)) % 8) == 0;
            wdata   = {$random(seed), $random(seed)};
            wmask   = soc_mem_pkg::strb_t'($random(seed));
            if (($unsigned($random(seed)) % 8) == 0) wmask = '0;
            addr = soc_mem_pkg::MEM_BASE + soc_mem_pkg::addr_t'(idx * 8);
            if (outside) begin
                if (n % 2) addr = addr + soc_mem_pkg::addr_t'(WIN_BYTES);   // above
                else addr = addr - 32'h1000;   // below base
            end
            if (sel < 2) begin
                kind = soc_mem_pkg::RD_WORD;
                name = "rd_word";
            end else if (sel < 4) begin
                kind = soc_mem_pkg::RD_LINE;
                name = "rd_line";
            end else begin
                kind = soc_mem_pkg::WR_WORD;
                name = (wmask == '0) ? "wr_zero_mask" : "wr_mask";
            end
            if (outside) name = {"decode_", name};
            issue(name, kind, addr, wdata, wmask);
        end

        // drain then wait a quiet window for extra responses
        while (exp_kind_q.size() != 0) @(posedge clk);
        repeat (20) @(posedge clk);

        $display("errors: line %0d, err %0d, kind %0d, other %0d",
                 line_errs, err_errs, kind_errs, other_errs);
        if (line_errs + err_errs + kind_errs + other_errs == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
rtl/soc_mem_pkg.sv
rtl/axi_pkg.sv
rtl/sync_fifo.sv
rtl/axi_rw_master.sv
rtl/axi_mem_slave.sv
rtl/mem_subsys_top.sv
sim/tb_mem_subsys.sv

//--- Bender.yml
package:
  name: mem_subsys

sources:
  - rtl/soc_mem_pkg.sv
  - rtl/axi_pkg.sv
  - rtl/sync_fifo.sv
  - rtl/axi_rw_master.sv
  - rtl/axi_mem_slave.sv
  - rtl/mem_subsys_top.sv
  - target: simulation
    files:
      - sim/tb_mem_subsys.sv
